//--- verilog/nes_bus_cfg.svh
`ifndef NES_BUS_CFG_SVH
`define NES_BUS_CFG_SVH

// Memory widths and depths
`define NES_RAM_ADDR_BITS 11
`define NES_PRG_ADDR_BITS 15
`define NES_RAM_SIZE (1 << `NES_RAM_ADDR_BITS)
`define NES_PRG_SIZE (1 << `NES_PRG_ADDR_BITS)

// Region bases of the CPU map
`define NES_PPU_BASE 16'h2000
`define NES_IO_BASE 16'h4000
`define NES_PRG_BASE 16'h8000

// Single registers in the IO window
`define NES_OAMDMA_ADDR 16'h4014
`define NES_APU_STATUS_ADDR 16'h4015
`define NES_CTLR1_ADDR 16'h4016
`define NES_CTLR2_ADDR 16'h4017

// Last address of the sound/IO window, 0x4018 and up is unmapped
`define NES_IO_LAST 16'h4017

`endif

//--- verilog/nes_bus_pkg.sv
`include "nes_bus_cfg.svh"

package nes_bus_pkg;

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0] cpu_data_t;
    typedef logic [`NES_RAM_ADDR_BITS-1:0] ram_addr_t;
    typedef logic [`NES_PRG_ADDR_BITS-1:0] prg_addr_t;
    typedef logic [4:0] io_reg_addr_t;

    // Picture register select, first eight follow addr[2:0]
    typedef enum logic [3:0] {
        PPUCTRL,
        PPUMASK,
        PPUSTATUS,
        OAMADDR,
        OAMDATA,
        PPUSCROLL,
        PPUADDR,
        PPUDATA,
        OAMDMA
    } ppu_reg_t;

    typedef enum logic [3:0] {
        REGION_RAM,
        REGION_PPU,
        REGION_OAMDMA,
        REGION_APU,
        REGION_APU_STATUS,
        REGION_CTLR1,
        REGION_CTLR2,
        REGION_OPEN,
        REGION_PRG
    } bus_region_t;

    typedef struct packed {
        ppu_reg_t sel;
        logic en;
        logic rw;
        cpu_data_t wr_data;
    } ppu_bus_t;

    typedef struct packed {
        io_reg_addr_t addr;
        cpu_data_t wr_data;
        logic valid;
        logic we;
    } apu_bus_t;

    // Pulses idle high
    typedef struct packed {
        logic pulse_p1;
        logic pulse_p2;
        logic latch;
    } ctlr_pins_t;

endpackage : nes_bus_pkg

//--- verilog/bus_decode.sv
`include "nes_bus_cfg.svh"

module bus_decode
    import nes_bus_pkg::*;
(
    input  cpu_addr_t addr,
    input  logic r_en,
    input  cpu_data_t w_data,
    output bus_region_t region,
    output ppu_bus_t ppu_bus,
    output apu_bus_t apu_bus
);

    logic io_hit;

    assign io_hit = (addr >= `NES_IO_BASE) && (addr <= `NES_IO_LAST);

    always_comb begin
        region = REGION_OPEN;
        if (addr < `NES_PPU_BASE) begin
            // 2 KB mirrored four times
            region = REGION_RAM;
        end else if (addr < `NES_IO_BASE) begin
            region = REGION_PPU;
        end else if (io_hit) begin
            case (addr)
                `NES_OAMDMA_ADDR: region = REGION_OAMDMA;
                `NES_APU_STATUS_ADDR: region = REGION_APU_STATUS;
                `NES_CTLR1_ADDR: region = REGION_CTLR1;
                `NES_CTLR2_ADDR: region = REGION_CTLR2;
                default: region = REGION_APU;
            endcase
        end else if (addr >= `NES_PRG_BASE) begin
            region = REGION_PRG;
        end
    end

    // Picture register port
    always_comb begin
        ppu_bus.sel = PPUCTRL;
        ppu_bus.en = 1'b0;
        ppu_bus.rw = ~r_en;
        ppu_bus.wr_data = w_data;
        if (region == REGION_PPU) begin
            // Eight registers repeat every 8 bytes
            ppu_bus.en = 1'b1;
            ppu_bus.sel = ppu_reg_t'({1'b0, addr[2:0]});
        end else if (region == REGION_OAMDMA) begin
            ppu_bus.en = 1'b1;
            ppu_bus.sel = OAMDMA;
        end
    end

    // Sound/IO pass-through
    always_comb begin
        apu_bus.addr = addr[4:0];
        apu_bus.wr_data = w_data;
        apu_bus.valid = io_hit;
        apu_bus.we = ~r_en;
    end

endmodule : bus_decode

//--- verilog/work_ram.sv
`include "nes_bus_cfg.svh"

module work_ram
    import nes_bus_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic clock_en,
    input  logic we,
    input  ram_addr_t addr,
    input  cpu_data_t wr_data,
    output cpu_data_t rd_data
);

    cpu_data_t mem [`NES_RAM_SIZE];

    // Array contents survive reset
    always_ff @(posedge clock) begin
        if (clock_en && we) begin
            mem[addr] <= wr_data;
        end
    end

    // Read register, returns old byte on a write cycle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (clock_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule : work_ram

//--- verilog/prg_rom.sv
`include "nes_bus_cfg.svh"

module prg_rom
    import nes_bus_pkg::*;
(
    input  logic clock,
    input  logic clock_en,
    input  prg_addr_t cpu_addr,
    input  logic load_we,
    input  prg_addr_t load_addr,
    input  cpu_data_t load_data,
    output cpu_data_t rd_data
);

    cpu_data_t mem [`NES_PRG_SIZE];
    prg_addr_t mem_addr;

    // Loader owns the address while writing
    assign mem_addr = load_we ? load_addr : cpu_addr;

    // Loader writes ignore clock_en
    always_ff @(posedge clock) begin
        if (load_we) begin
            mem[mem_addr] <= load_data;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_en && !load_we) begin
            rd_data <= mem[mem_addr];
        end
    end

endmodule : prg_rom

//--- verilog/ctlr_port.sv
module ctlr_port
    import nes_bus_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic clock_en,
    input  bus_region_t region,
    input  logic r_en,
    input  logic latch_data,
    input  logic ctlr_data_p1,
    input  logic ctlr_data_p2,
    output ctlr_pins_t ctlr,
    output logic button_data
);

    ctlr_pins_t ctlr_next;
    logic button_next;
    logic p1_access;
    logic p2_access;

    assign p1_access = (region == REGION_CTLR1);
    assign p2_access = (region == REGION_CTLR2);

    always_comb begin
        ctlr_next.latch = ctlr.latch;
        if (p1_access && !r_en) begin
            ctlr_next.latch = latch_data;
        end
        // One enabled cycle low per read
        ctlr_next.pulse_p1 = !(p1_access && r_en);
        ctlr_next.pulse_p2 = !(p2_access && r_en);
    end

    // Pad data pins are active low
    assign button_next = p1_access ? ~ctlr_data_p1 : ~ctlr_data_p2;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ctlr.pulse_p1 <= 1'b1;
            ctlr.pulse_p2 <= 1'b1;
            ctlr.latch <= 1'b0;
            button_data <= 1'b0;
        end else if (clock_en) begin
            ctlr <= ctlr_next;
            button_data <= button_next;
        end
    end

endmodule : ctlr_port

//--- verilog/cpu_bus.sv
module cpu_bus
    import nes_bus_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic clock_en,

    // CPU side
    input  cpu_addr_t addr,
    input  logic r_en,
    input  cpu_data_t w_data,
    output cpu_data_t r_data,

    // Picture processor registers
    output ppu_bus_t ppu_bus,
    input  cpu_data_t reg_data_rd,

    // Sound/IO registers
    output apu_bus_t apu_bus,
    input  cpu_data_t apu_read_data,

    // Controller pins
    input  logic ctlr_data_p1,
    input  logic ctlr_data_p2,
    output ctlr_pins_t ctlr,

    // Program loader
    input  logic prom_we,
    input  prg_addr_t prom_wr_addr,
    input  cpu_data_t prom_wr_data
);

    bus_region_t region;
    bus_region_t region_q;
    cpu_data_t open_bus_q;
    cpu_data_t ram_rd_data;
    cpu_data_t prg_rd_data;
    logic ram_we;
    logic button_data;

    bus_decode u_decode (
        .addr(addr),
        .r_en(r_en),
        .w_data(w_data),
        .region(region),
        .ppu_bus(ppu_bus),
        .apu_bus(apu_bus)
    );

    assign ram_we = (region == REGION_RAM) && !r_en;

    // Low address bits give the mirror
    work_ram u_ram (
        .clock(clock),
        .reset_n(reset_n),
        .clock_en(clock_en),
        .we(ram_we),
        .addr(ram_addr_t'(addr)),
        .wr_data(w_data),
        .rd_data(ram_rd_data)
    );

    prg_rom u_prg (
        .clock(clock),
        .clock_en(clock_en),
        .cpu_addr(prg_addr_t'(addr)),
        .load_we(prom_we),
        .load_addr(prom_wr_addr),
        .load_data(prom_wr_data),
        .rd_data(prg_rd_data)
    );

    ctlr_port u_ctlr (
        .clock(clock),
        .reset_n(reset_n),
        .clock_en(clock_en),
        .region(region),
        .r_en(r_en),
        .latch_data(w_data[0]),
        .ctlr_data_p1(ctlr_data_p1),
        .ctlr_data_p2(ctlr_data_p2),
        .ctlr(ctlr),
        .button_data(button_data)
    );

    // Region of the access now being answered, and the last byte driven
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            region_q <= REGION_OPEN;
            open_bus_q <= '0;
        end else if (clock_en) begin
            region_q <= region;
            open_bus_q <= r_data;
        end
    end

    always_comb begin
        case (region_q)
            REGION_RAM: r_data = ram_rd_data;
            REGION_PRG: r_data = prg_rd_data;
            REGION_PPU,
            REGION_OAMDMA: r_data = reg_data_rd;
            REGION_APU_STATUS: r_data = apu_read_data;
            REGION_CTLR1,
            REGION_CTLR2: r_data = {7'b0, button_data};
            // Write-only sound registers read as open bus
            default: r_data = open_bus_q;
        endcase
    end

endmodule : cpu_bus

//--- tests/cpu_bus_chk.sv
`include "nes_bus_cfg.svh"

module cpu_bus_chk
    import nes_bus_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic clock_en,
    input  cpu_addr_t addr,
    input  logic r_en,
    input  bus_region_t region,
    input  ppu_bus_t ppu_bus,
    input  ctlr_pins_t ctlr
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors = 0;
    logic ctlr1_write;

    assign ctlr1_write = clock_en && (region == REGION_CTLR1) && !r_en;

    // A pulse ends on the next enabled edge unless that pad is read again
    pulse_p1_one_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        (clock_en && !ctlr.pulse_p1 && !(region == REGION_CTLR1 && r_en)) |=> ctlr.pulse_p1)
    else begin
        $error("pulse_p1 stayed low for more than one enabled cycle");
        assert_errors++;
    end

    pulse_p2_one_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        (clock_en && !ctlr.pulse_p2 && !(region == REGION_CTLR2 && r_en)) |=> ctlr.pulse_p2)
    else begin
        $error("pulse_p2 stayed low for more than one enabled cycle");
        assert_errors++;
    end

    latch_on_write_only: assert property (@(posedge clock) disable iff (!reset_n)
        !ctlr1_write |=> $stable(ctlr.latch))
    else begin
        $error("latch changed without an enabled write to 0x4016");
        assert_errors++;
    end

    // Enable only inside the picture window or at the DMA register
    ppu_en_addr: assert property (@(posedge clock) disable iff (!reset_n)
        ppu_bus.en |-> ((addr >= `NES_PPU_BASE && addr < `NES_IO_BASE)
                        || addr == `NES_OAMDMA_ADDR))
    else begin
        $error("ppu_bus.en high outside the picture and OAM DMA addresses");
        assert_errors++;
    end

    // Pins show their reset values one edge after reset is sampled
    pulses_idle_in_reset: assert property (@(posedge clock)
        !reset_n |=> (ctlr.pulse_p1 && ctlr.pulse_p2))
    else begin
        $error("controller pulses not high during reset");
        assert_errors++;
    end

endmodule : cpu_bus_chk

bind cpu_bus cpu_bus_chk chk0 (
    .clock(clock),
    .reset_n(reset_n),
    .clock_en(clock_en),
    .addr(addr),
    .r_en(r_en),
    .region(region),
    .ppu_bus(ppu_bus),
    .ctlr(ctlr)
);

//--- tests/cpu_bus_tb.sv
`include "nes_bus_cfg.svh"

module cpu_bus_tb
    import nes_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 2000;

    // Everything the testbench drives into the DUT
    typedef struct packed {
        logic reset_n;
        logic clock_en;
        cpu_addr_t addr;
        logic r_en;
        cpu_data_t w_data;
        cpu_data_t reg_data_rd;
        cpu_data_t apu_read_data;
        logic ctlr_data_p1;
        logic ctlr_data_p2;
        logic prom_we;
        prg_addr_t prom_wr_addr;
        cpu_data_t prom_wr_data;
    } bus_inputs_t;

    logic clock = 1'b0;
    bus_inputs_t drv = '0;
    bus_inputs_t drv_next = '0;
    cpu_data_t r_data;
    ppu_bus_t ppu_bus;
    apu_bus_t apu_bus;
    ctlr_pins_t ctlr;
    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int cycle_count = 0;

    cpu_bus dut0 (
        .clock(clock),
        .reset_n(drv.reset_n),
        .clock_en(drv.clock_en),
        .addr(drv.addr),
        .r_en(drv.r_en),
        .w_data(drv.w_data),
        .r_data(r_data),
        .ppu_bus(ppu_bus),
        .reg_data_rd(drv.reg_data_rd),
        .apu_bus(apu_bus),
        .apu_read_data(drv.apu_read_data),
        .ctlr_data_p1(drv.ctlr_data_p1),
        .ctlr_data_p2(drv.ctlr_data_p2),
        .ctlr(ctlr),
        .prom_we(drv.prom_we),
        .prom_wr_addr(drv.prom_wr_addr),
        .prom_wr_data(drv.prom_wr_data)
    );

    always #50 clock = ~clock;

    // Tasks set drv_next at the falling edge, applied here
    always @(posedge clock) begin
        drv <= drv_next;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_data(input string name, input cpu_data_t expected,
                                input cpu_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0d ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_ppu(input string name, input ppu_bus_t expected,
                               input ppu_bus_t actual);
        ppu_bus_t masked;
        check_count++;
        masked = actual;
        // sel is a don't-care while the port is idle
        if (!expected.en) begin
            masked.sel = expected.sel;
        end
        if (masked !== expected) begin
            error_count++;
            $display("Fail at %0d ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_apu(input string name, input apu_bus_t expected,
                               input apu_bus_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0d ns: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_ctlr(input string name, input ctlr_pins_t expected,
                                input ctlr_pins_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    function automatic ppu_reg_t expected_sel(input logic [2:0] idx);
        case (idx)
            3'd0: return PPUCTRL;
            3'd1: return PPUMASK;
            3'd2: return PPUSTATUS;
            3'd3: return OAMADDR;
            3'd4: return OAMDATA;
            3'd5: return PPUSCROLL;
            3'd6: return PPUADDR;
            default: return PPUDATA;
        endcase
    endfunction

    task automatic drive(input cpu_addr_t a, input logic ren, input cpu_data_t wd,
                         input logic cen);
        @(negedge clock);
        drv_next.addr = a;
        drv_next.r_en = ren;
        drv_next.w_data = wd;
        drv_next.clock_en = cen;
        @(posedge clock);
    endtask

    // One enabled access, returns at the falling edge after the edge that took it
    task automatic access(input cpu_addr_t a, input logic ren, input cpu_data_t wd);
        drive(a, ren, wd, 1'b1);
        drive(a, 1'b1, wd, 1'b0);
        @(negedge clock);
    endtask

    task automatic load_byte(input prg_addr_t a, input cpu_data_t d);
        @(negedge clock);
        drv_next.prom_we = 1'b1;
        drv_next.prom_wr_addr = a;
        drv_next.prom_wr_data = d;
        @(negedge clock);
        drv_next.prom_we = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("%s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic reset_and_idle();
        int errors_before;
        errors_before = error_count;
        repeat (10) @(posedge clock);
        @(negedge clock);
        drv_next.reset_n = 1'b1;
        drv_next.r_en = 1'b1;
        @(negedge clock);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b1, 1'b1, 1'b0}, ctlr);
        compare_data("r_data", 8'h00, r_data);
        finish_test("reset_and_idle", errors_before);
    endtask

    task automatic ram_mirror();
        int errors_before;
        cpu_addr_t addrs [8];
        cpu_data_t data [8];
        errors_before = error_count;
        // One address per 256-byte block keeps them distinct
        for (int i = 0; i < 8; i++) begin
            addrs[i] = cpu_addr_t'((i << 8) | ($urandom & 32'hFF));
            data[i] = cpu_data_t'($urandom);
            access(addrs[i], 1'b0, data[i]);
        end
        for (int i = 0; i < 8; i++) begin
            access(addrs[i] + 16'h0800, 1'b1, 8'h00);
            compare_data("r_data", data[i], r_data);
            access(addrs[i] + 16'h1800, 1'b1, 8'h00);
            compare_data("r_data", data[i], r_data);
        end
        drive(addrs[0], 1'b0, ~data[0], 1'b0);
        access(addrs[0], 1'b1, 8'h00);
        compare_data("r_data", data[0], r_data);
        finish_test("ram_mirror", errors_before);
    endtask

    task automatic prg_memory();
        int errors_before;
        prg_addr_t addrs [8];
        cpu_data_t data [8];
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = prg_addr_t'((i << 12) | ($urandom & 32'hFFF));
            data[i] = cpu_data_t'($urandom);
            load_byte(addrs[i], data[i]);
        end
        for (int i = 0; i < 8; i++) begin
            access(`NES_PRG_BASE | cpu_addr_t'(addrs[i]), 1'b1, 8'h00);
            compare_data("r_data", data[i], r_data);
        end
        access(`NES_PRG_BASE | cpu_addr_t'(addrs[0]), 1'b0, ~data[0]);
        access(`NES_PRG_BASE | cpu_addr_t'(addrs[0]), 1'b1, 8'h00);
        compare_data("r_data", data[0], r_data);
        finish_test("prg_memory", errors_before);
    endtask

    task automatic ppu_decode();
        int errors_before;
        cpu_addr_t a;
        logic ren;
        cpu_data_t wd;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            a = cpu_addr_t'(16'h2000 | ($urandom & 32'h1FFF));
            ren = 1'($urandom & 1);
            wd = cpu_data_t'($urandom);
            drive(a, ren, wd, 1'b0);
            @(negedge clock);
            compare_ppu("ppu_bus", ppu_bus_t'{expected_sel(a[2:0]), 1'b1, ~ren, wd}, ppu_bus);
        end
        drive(`NES_OAMDMA_ADDR, 1'b0, wd, 1'b0);
        @(negedge clock);
        compare_ppu("ppu_bus", ppu_bus_t'{OAMDMA, 1'b1, 1'b1, wd}, ppu_bus);
        wd = cpu_data_t'($urandom);
        drv_next.reg_data_rd = wd;
        access(a, 1'b1, 8'h00);
        compare_data("r_data", wd, r_data);
        drive(16'h4018, 1'b1, 8'h00, 1'b0);
        @(negedge clock);
        compare_ppu("ppu_bus", ppu_bus_t'{PPUCTRL, 1'b0, 1'b0, 8'h00}, ppu_bus);
        finish_test("ppu_decode", errors_before);
    endtask

    task automatic apu_port();
        int errors_before;
        cpu_data_t wd;
        cpu_data_t status;
        errors_before = error_count;
        wd = cpu_data_t'($urandom);
        drive(16'h4003, 1'b0, wd, 1'b0);
        @(negedge clock);
        compare_apu("apu_bus", apu_bus_t'{5'd3, wd, 1'b1, 1'b1}, apu_bus);
        status = cpu_data_t'($urandom);
        drv_next.apu_read_data = status;
        access(`NES_APU_STATUS_ADDR, 1'b1, 8'h00);
        compare_data("r_data", status, r_data);
        // Unmapped reads repeat the last byte on the bus
        access(16'h4018, 1'b1, 8'h00);
        compare_apu("apu_bus", apu_bus_t'{5'h18, 8'h00, 1'b0, 1'b0}, apu_bus);
        compare_data("r_data", status, r_data);
        access(16'h5000, 1'b1, 8'h00);
        compare_apu("apu_bus", apu_bus_t'{5'h00, 8'h00, 1'b0, 1'b0}, apu_bus);
        compare_data("r_data", status, r_data);
        finish_test("apu_port", errors_before);
    endtask

    task automatic ctlr_protocol();
        int errors_before;
        logic pin;
        errors_before = error_count;
        access(`NES_CTLR1_ADDR, 1'b0, 8'h01);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b1, 1'b1, 1'b1}, ctlr);
        access(`NES_CTLR1_ADDR, 1'b0, 8'h00);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b1, 1'b1, 1'b0}, ctlr);
        // Other pad pin held opposite so a wrong capture shows
        pin = 1'($urandom & 1);
        drv_next.ctlr_data_p1 = pin;
        drv_next.ctlr_data_p2 = ~pin;
        access(`NES_CTLR1_ADDR, 1'b1, 8'h00);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b0, 1'b1, 1'b0}, ctlr);
        compare_data("r_data", cpu_data_t'({7'b0, ~pin}), r_data);
        access(16'h5000, 1'b1, 8'h00);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b1, 1'b1, 1'b0}, ctlr);
        pin = 1'($urandom & 1);
        drv_next.ctlr_data_p2 = pin;
        drv_next.ctlr_data_p1 = ~pin;
        access(`NES_CTLR2_ADDR, 1'b1, 8'h00);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b1, 1'b0, 1'b0}, ctlr);
        compare_data("r_data", cpu_data_t'({7'b0, ~pin}), r_data);
        access(16'h5000, 1'b1, 8'h00);
        compare_ctlr("ctlr", ctlr_pins_t'{1'b1, 1'b1, 1'b0}, ctlr);
        finish_test("ctlr_protocol", errors_before);
    endtask

    initial begin
        void'($urandom(61968));
        reset_and_idle();
        ram_mirror();
        prg_memory();
        ppu_decode();
        apu_port();
        ctlr_protocol();
        error_count += dut0.chk0.assert_errors;
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : cpu_bus_tb

//--- filelist.f
+incdir+verilog
verilog/nes_bus_pkg.sv
verilog/bus_decode.sv
verilog/work_ram.sv
verilog/prg_rom.sv
verilog/ctlr_port.sv
verilog/cpu_bus.sv
tests/cpu_bus_chk.sv
tests/cpu_bus_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := cpu_bus_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
COMMON     := --assert --timescale 1ns/100ps --top-module $(TOP)
LINT_FLAGS := --lint-only --timing $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON) -Mdir $(BUILD_DIR)
RUN_ARGS   := +verilator+error+limit+100
PASS_TEXT  := Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
